/* files.f */
+incdir+tests
verilog/csr_pkg.sv
verilog/exc_pkg.sv
verilog/csr_access.sv
verilog/csr_trap_regs.sv
verilog/csr_save_regs.sv
verilog/csr_timer.sv
verilog/csr_interrupt.sv
verilog/csr_unit.sv
tests/csr_unit_tb.sv

/* tests/csr_unit_tests.svh */
// poll ESTAT until the timer pending bit shows up
task automatic wait_timer_pending(input string test_name);
    int cycles;
    cycles = 0;
    @(posedge clk);
    csr_req <= '{re: 1'b1, we: 1'b0, num: csr_pkg::ESTAT, wmask: '0, wvalue: '0};
    @(negedge clk);
    while (csr_rvalue[11] !== 1'b1) begin
        if (cycles == TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout in %s, timer pending bit never set", test_name));
        end
        cycles++;
        @(negedge clk);
    end
endtask

// watch TVAL while waiting for has_int from the timer
task automatic wait_periodic_expiry(input string test_name);
    int cycles;
    cycles = 0;
    @(posedge clk);
    csr_req <= '{re: 1'b1, we: 1'b0, num: csr_pkg::TVAL, wmask: '0, wvalue: '0};
    @(negedge clk);
    while (has_int !== 1'b1) begin
        if (csr_rvalue === '1) begin
            stop_with_error($sformatf("MISMATCH %s expected below ffffffff actual %08h",
                                      test_name, csr_rvalue));
        end
        if (cycles == TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout in %s, periodic timer never expired", test_name));
        end
        cycles++;
        @(negedge clk);
    end
endtask

task automatic test_reset_and_writes();
    csr_pkg::csr_word_t rdata;
    csr_pkg::csr_word_t old_value;
    csr_pkg::csr_word_t mask;
    csr_pkg::csr_word_t value;
    csr_pkg::csr_word_t expected;
    csr_pkg::csr_num_t  num;
    expect_csr("reset_crmd", csr_pkg::CRMD, 32'h8);
    expect_csr("reset_prmd", csr_pkg::PRMD, 32'h0);
    expect_csr("reset_ecfg", csr_pkg::ECFG, 32'h0);
    read_csr(csr_pkg::ESTAT, rdata);
    check_word("reset_estat_is", 32'h0, rdata & 32'h1fff);
    expect_csr("reset_tval", csr_pkg::TVAL, '1);
    read_csr(csr_pkg::TCFG, rdata);
    check_bit("reset_tcfg_en", 1'b0, rdata[0]);
    check_bit("reset_has_int", 1'b0, has_int);
    // save bank, then ERA, then EENTRY
    for (int i = 0; i < SAVE_COUNT + 2; i++) begin
        if (i < SAVE_COUNT) begin
            num = csr_pkg::csr_num_t'(csr_pkg::SAVE_BASE + i);
        end else if (i == SAVE_COUNT) begin
            num = csr_pkg::ERA;
        end else begin
            num = csr_pkg::EENTRY;
        end
        old_value = rand_word();
        write_csr(num, '1, old_value);
        mask  = rand_word();
        value = rand_word();
        write_csr(num, mask, value);
        expected = merge_expected(old_value, mask, value);
        if (num == csr_pkg::EENTRY) begin
            expected[5:0] = '0;
        end
        expect_csr("masked_write", num, expected);
    end
    check_word("eentry_output", expected, csr_eentry);
    @(posedge clk);
    csr_req <= '{re: 1'b0, we: 1'b0, num: csr_pkg::ERA, wmask: '0, wvalue: '0};
    @(negedge clk);
    check_word("read_disabled", 32'h0, csr_rvalue);
endtask

task automatic test_exception();
    exc_pkg::exc_event_t ev;
    exc_pkg::exc_event_t ret;
    csr_pkg::csr_word_t  rdata;
    csr_pkg::csr_word_t  word;
    write_csr(csr_pkg::CRMD, 32'h7, 32'h7);
    expect_csr("exception_crmd_set", csr_pkg::CRMD, 32'hf);
    word        = rand_word();
    ev          = '0;
    ev.ex       = 1'b1;
    ev.ecode    = exc_pkg::ECODE_ALE;
    ev.esubcode = word[8:0];
    ev.pc       = rand_word();
    ev.vaddr    = rand_word();
    pulse_event(ev);
    expect_csr("exception_crmd", csr_pkg::CRMD, 32'h8);
    expect_csr("exception_prmd", csr_pkg::PRMD, 32'h7);
    expect_csr("exception_era", csr_pkg::ERA, ev.pc);
    expect_csr("exception_badv_ale", csr_pkg::BADV, ev.vaddr);
    read_csr(csr_pkg::ESTAT, rdata);
    check_word("exception_estat_code", {1'b0, ev.esubcode, ev.ecode, 16'b0},
               rdata & 32'h7fff_0000);
    ret      = '0;
    ret.ertn = 1'b1;
    pulse_event(ret);
    expect_csr("ertn_crmd", csr_pkg::CRMD, 32'hf);
    // ADEF takes the pc as bad address
    ev.ecode    = exc_pkg::ECODE_ADE;
    ev.esubcode = '0;
    ev.pc       = rand_word();
    ev.vaddr    = rand_word();
    pulse_event(ev);
    expect_csr("exception_badv_adef", csr_pkg::BADV, ev.pc);
    expect_csr("exception_adef_crmd", csr_pkg::CRMD, 32'h8);
    expect_csr("exception_adef_prmd", csr_pkg::PRMD, 32'h7);
    pulse_event(ret);
    expect_csr("ertn_adef_crmd", csr_pkg::CRMD, 32'hf);
endtask

task automatic test_interrupts();
    csr_pkg::csr_word_t rdata;
    csr_pkg::csr_word_t word;
    int                 line;
    write_csr(csr_pkg::ECFG, '1, 32'h1);
    write_csr(csr_pkg::ESTAT, 32'h3, 32'h1);
    write_csr(csr_pkg::CRMD, 32'h4, 32'h4);
    @(negedge clk);
    check_bit("interrupt_sw_ie1", 1'b1, has_int);
    write_csr(csr_pkg::CRMD, 32'h4, 32'h0);
    @(negedge clk);
    check_bit("interrupt_sw_ie0", 1'b0, has_int);
    write_csr(csr_pkg::CRMD, 32'h4, 32'h4);
    @(negedge clk);
    check_bit("interrupt_sw_ie1_again", 1'b1, has_int);
    write_csr(csr_pkg::ESTAT, 32'h3, 32'h0);
    @(negedge clk);
    check_bit("interrupt_sw_cleared", 1'b0, has_int);
    // one hardware line, seen a cycle late
    word = rand_word();
    line = int'(word[2:0]);
    write_csr(csr_pkg::ECFG, '1, 32'h4 << line);
    @(posedge clk);
    hw_int_in <= 8'h1 << line;
    csr_req   <= '{re: 1'b1, we: 1'b0, num: csr_pkg::ESTAT, wmask: '0, wvalue: '0};
    @(negedge clk);
    check_word("interrupt_hw_delay", 32'h0, csr_rvalue & 32'h1fff);
    check_bit("interrupt_hw_delay_int", 1'b0, has_int);
    @(negedge clk);
    check_word("interrupt_hw_sampled", 32'h4 << line, csr_rvalue & 32'h1fff);
    check_bit("interrupt_hw_int", 1'b1, has_int);
    // enable and status bit 10 stay zero
    write_csr(csr_pkg::ECFG, '1, '1);
    expect_csr("interrupt_ecfg_bit10", csr_pkg::ECFG, 32'h1bff);
    @(posedge clk);
    ipi_int_in <= 1'b1;
    write_csr(csr_pkg::ESTAT, '1, '1);
    read_csr(csr_pkg::ESTAT, rdata);
    check_word("interrupt_estat_bit10", 32'h1003 | (32'h4 << line), rdata & 32'h1fff);
    @(posedge clk);
    hw_int_in  <= '0;
    ipi_int_in <= 1'b0;
    write_csr(csr_pkg::ESTAT, 32'h3, 32'h0);
    write_csr(csr_pkg::ECFG, '1, 32'h0);
    @(negedge clk);
    check_bit("interrupt_cleanup", 1'b0, has_int);
endtask

task automatic test_oneshot_timer();
    csr_pkg::csr_word_t rdata;
    csr_pkg::csr_word_t tid_value;
    csr_pkg::csr_word_t initval;
    expect_csr("timer_tid_reset", csr_pkg::TID, coreid_in);
    tid_value = rand_word();
    write_csr(csr_pkg::TID, '1, tid_value);
    expect_csr("timer_tid_write", csr_pkg::TID, tid_value);
    initval = 3 + (rand_word() & 32'h3);
    write_then_read(csr_pkg::TCFG, '1, (initval << 2) | 32'h1, csr_pkg::TVAL, rdata);
    check_word("timer_load", initval << 2, rdata);
    wait_timer_pending("timer_oneshot");
    expect_csr("timer_oneshot_end", csr_pkg::TVAL, '1);
    write_csr(csr_pkg::TICLR, 32'h1, 32'h1);
    read_csr(csr_pkg::ESTAT, rdata);
    check_bit("timer_oneshot_clear", 1'b0, rdata[11]);
endtask

task automatic test_periodic_timer();
    csr_pkg::csr_word_t rdata;
    csr_pkg::csr_word_t initval;
    initval = 3 + (rand_word() & 32'h3);
    // timer bit routed to has_int
    write_csr(csr_pkg::ECFG, '1, 32'h800);
    write_csr(csr_pkg::CRMD, 32'h4, 32'h4);
    write_csr(csr_pkg::TCFG, '1, (initval << 2) | 32'h3);
    wait_periodic_expiry("timer_periodic_first");
    write_csr(csr_pkg::TICLR, 32'h1, 32'h1);
    @(negedge clk);
    check_bit("timer_periodic_clear", 1'b0, has_int);
    wait_periodic_expiry("timer_periodic_second");
    read_csr(csr_pkg::ESTAT, rdata);
    check_bit("timer_periodic_pending", 1'b1, rdata[11]);
    write_csr(csr_pkg::TCFG, 32'h1, 32'h0);
    write_csr(csr_pkg::TICLR, 32'h1, 32'h1);
    read_csr(csr_pkg::ESTAT, rdata);
    check_bit("timer_periodic_stop", 1'b0, rdata[11]);
endtask

/* tests/csr_unit_tb.sv */
module csr_unit_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int SAVE_COUNT     = 4;
    localparam int TIMEOUT_CYCLES = 200;

    logic                clk;
    logic                reset;
    csr_pkg::csr_req_t   csr_req;
    exc_pkg::exc_event_t exc;
    csr_pkg::csr_word_t  coreid_in;
    logic [7:0]          hw_int_in;
    logic                ipi_int_in;
    csr_pkg::csr_word_t  csr_rvalue;
    csr_pkg::csr_word_t  csr_eentry;
    logic                has_int;
    int                  seed;

    csr_unit #(
        .SAVE_COUNT (SAVE_COUNT)
    ) i_csr_unit (
        .clk        (clk),
        .reset      (reset),
        .csr_req    (csr_req),
        .exc        (exc),
        .coreid_in  (coreid_in),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .csr_rvalue (csr_rvalue),
        .csr_eentry (csr_eentry),
        .has_int    (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string test_name, input csr_pkg::csr_word_t expected,
                              input csr_pkg::csr_word_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("MISMATCH %s expected %08h actual %08h",
                                      test_name, expected, actual));
        end
    endtask

    task automatic check_bit(input string test_name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("MISMATCH %s expected %b actual %b",
                                      test_name, expected, actual));
        end
    endtask

    function automatic csr_pkg::csr_word_t rand_word();
        return $random(seed);
    endfunction

    // reference model of a masked write, bit by bit
    function automatic csr_pkg::csr_word_t merge_expected(input csr_pkg::csr_word_t old_value,
                                                          input csr_pkg::csr_word_t mask,
                                                          input csr_pkg::csr_word_t value);
        csr_pkg::csr_word_t result;
        for (int i = 0; i < 32; i++) begin
            result[i] = mask[i] ? value[i] : old_value[i];
        end
        return result;
    endfunction

    // write lands at the second edge
    task automatic write_csr(input csr_pkg::csr_num_t num, input csr_pkg::csr_word_t mask,
                             input csr_pkg::csr_word_t value);
        @(posedge clk);
        csr_req <= '{re: 1'b0, we: 1'b1, num: num, wmask: mask, wvalue: value};
        @(posedge clk);
        csr_req <= '0;
    endtask

    // read is combinational, sampled mid-cycle
    task automatic read_csr(input csr_pkg::csr_num_t num, output csr_pkg::csr_word_t value);
        @(posedge clk);
        csr_req <= '{re: 1'b1, we: 1'b0, num: num, wmask: '0, wvalue: '0};
        @(negedge clk);
        value = csr_rvalue;
    endtask

    // read in the cycle right after the write takes effect
    task automatic write_then_read(input csr_pkg::csr_num_t wnum, input csr_pkg::csr_word_t mask,
                                   input csr_pkg::csr_word_t value, input csr_pkg::csr_num_t rnum,
                                   output csr_pkg::csr_word_t rvalue);
        @(posedge clk);
        csr_req <= '{re: 1'b0, we: 1'b1, num: wnum, wmask: mask, wvalue: value};
        @(posedge clk);
        csr_req <= '{re: 1'b1, we: 1'b0, num: rnum, wmask: '0, wvalue: '0};
        @(negedge clk);
        rvalue = csr_rvalue;
    endtask

    task automatic expect_csr(input string test_name, input csr_pkg::csr_num_t num,
                              input csr_pkg::csr_word_t expected);
        csr_pkg::csr_word_t value;
        read_csr(num, value);
        check_word(test_name, expected, value);
    endtask

    // one-cycle exception or ertn event
    task automatic pulse_event(input exc_pkg::exc_event_t ev);
        @(posedge clk);
        exc <= ev;
        @(posedge clk);
        exc <= '0;
    endtask

    `include "csr_unit_tests.svh"

    initial begin
        seed       = 1720;
        reset      = 1'b1;
        csr_req    = '0;
        exc        = '0;
        coreid_in  = rand_word();
        hw_int_in  = '0;
        ipi_int_in = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset_and_writes();
        test_exception();
        test_interrupts();
        test_oneshot_timer();
        test_periodic_timer();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verilog/csr_unit.sv */
module csr_unit #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_req_t    csr_req,
    input  exc_pkg::exc_event_t  exc,
    input  csr_pkg::csr_word_t   coreid_in,
    input  logic [7:0]           hw_int_in,
    input  logic                 ipi_int_in,
    output csr_pkg::csr_word_t   csr_rvalue,
    output csr_pkg::csr_word_t   csr_eentry,
    output logic                 has_int
);

    csr_pkg::csr_wr_t      csr_wr;
    logic [SAVE_COUNT-1:0] save_wr;
    csr_pkg::csr_word_t    wmask;
    csr_pkg::csr_word_t    wvalue;
    csr_pkg::trap_view_t   trap_view;
    csr_pkg::timer_view_t  timer_view;
    csr_pkg::intr_view_t   intr_view;
    csr_pkg::csr_word_t    save_values [SAVE_COUNT];
    logic                  crmd_ie;
    logic                  timer_int;

    // decode and read-back
    csr_access #(
        .SAVE_COUNT (SAVE_COUNT)
    ) i_csr_access (
        .csr_req     (csr_req),
        .trap_view   (trap_view),
        .timer_view  (timer_view),
        .intr_view   (intr_view),
        .save_values (save_values),
        .csr_wr      (csr_wr),
        .save_wr     (save_wr),
        .wmask       (wmask),
        .wvalue      (wvalue),
        .csr_rvalue  (csr_rvalue)
    );

    csr_trap_regs i_csr_trap_regs (
        .clk        (clk),
        .reset      (reset),
        .exc        (exc),
        .csr_wr     (csr_wr),
        .wmask      (wmask),
        .wvalue     (wvalue),
        .trap_view  (trap_view),
        .crmd_ie    (crmd_ie),
        .csr_eentry (csr_eentry)
    );

    csr_save_regs #(
        .SAVE_COUNT (SAVE_COUNT)
    ) i_csr_save_regs (
        .clk         (clk),
        .save_wr     (save_wr),
        .wmask       (wmask),
        .wvalue      (wvalue),
        .save_values (save_values)
    );

    csr_timer i_csr_timer (
        .clk        (clk),
        .reset      (reset),
        .coreid_in  (coreid_in),
        .csr_wr     (csr_wr),
        .wmask      (wmask),
        .wvalue     (wvalue),
        .timer_view (timer_view),
        .timer_int  (timer_int)
    );

    csr_interrupt i_csr_interrupt (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .wmask      (wmask),
        .wvalue     (wvalue),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .timer_int  (timer_int),
        .crmd_ie    (crmd_ie),
        .intr_view  (intr_view),
        .has_int    (has_int)
    );

endmodule

/* verilog/csr_interrupt.sv */
module csr_interrupt (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_wr_t     csr_wr,
    input  csr_pkg::csr_word_t   wmask,
    input  csr_pkg::csr_word_t   wvalue,
    input  logic [7:0]           hw_int_in,
    input  logic                 ipi_int_in,
    input  logic                 timer_int,
    input  logic                 crmd_ie,
    output csr_pkg::intr_view_t  intr_view,
    output logic                 has_int
);

    logic [12:0]        ecfg_lie;
    logic [1:0]         sw_int;
    logic [7:0]         hw_int;
    logic               ipi_int;
    logic [12:0]        estat_is;
    csr_pkg::csr_word_t ecfg_word;
    csr_pkg::csr_word_t ecfg_next;
    csr_pkg::csr_word_t estat_next;

    assign ecfg_word  = {19'b0, ecfg_lie};
    assign ecfg_next  = csr_pkg::masked_merge(ecfg_word, wmask, wvalue);
    // only the software bits of ESTAT take writes
    assign estat_next = csr_pkg::masked_merge({30'b0, sw_int}, wmask, wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            sw_int   <= '0;
            hw_int   <= '0;
            ipi_int  <= 1'b0;
        end else begin
            if (csr_wr.ecfg) begin
                // enable 10 has no source
                ecfg_lie <= {ecfg_next[12:11], 1'b0, ecfg_next[9:0]};
            end
            if (csr_wr.estat) begin
                sw_int <= estat_next[1:0];
            end
            // external lines, one cycle of sampling delay
            hw_int  <= hw_int_in;
            ipi_int <= ipi_int_in;
        end
    end

    assign estat_is = {ipi_int, timer_int, 1'b0, hw_int, sw_int};

    assign has_int = ((estat_is[11:0] & ecfg_lie[11:0]) != 12'b0) && crmd_ie;

    assign intr_view = '{ecfg: ecfg_word, is: estat_is};

endmodule

/* verilog/csr_timer.sv */
module csr_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::csr_word_t    coreid_in,
    input  csr_pkg::csr_wr_t      csr_wr,
    input  csr_pkg::csr_word_t    wmask,
    input  csr_pkg::csr_word_t    wvalue,
    output csr_pkg::timer_view_t  timer_view,
    output logic                  timer_int
);

    csr_pkg::csr_word_t tid;
    logic               tcfg_en;
    logic               tcfg_periodic;
    logic [29:0]        tcfg_initval;
    csr_pkg::csr_word_t tcfg_word;
    csr_pkg::csr_word_t tcfg_next;
    csr_pkg::csr_word_t timer_cnt;
    logic               cnt_zero;
    logic               ticlr_hit;

    assign tcfg_word = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next = csr_pkg::masked_merge(tcfg_word, wmask, wvalue);
    assign cnt_zero  = (timer_cnt == '0);
    assign ticlr_hit = csr_wr.ticlr && wmask[0] && wvalue[0];

    // core id loaded at reset, writable later
    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= coreid_in;
        end else if (csr_wr.tid) begin
            tid <= csr_pkg::masked_merge(tid, wmask, wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (csr_wr.tcfg) begin
            tcfg_en <= tcfg_next[0];
        end
        if (csr_wr.tcfg) begin
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[31:2];
        end
    end

    // countdown, all ones means stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (csr_wr.tcfg && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[31:2], 2'b0};
        end else if (tcfg_en && (timer_cnt != '1)) begin
            if (cnt_zero && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b0};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    // pending bit, expiry wins over clear
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (cnt_zero) begin
            timer_int <= 1'b1;
        end else if (ticlr_hit) begin
            timer_int <= 1'b0;
        end
    end

    assign timer_view = '{tid: tid, tcfg: tcfg_word, tval: timer_cnt};

endmodule

/* verilog/csr_save_regs.sv */
module csr_save_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                   clk,
    input  logic [SAVE_COUNT-1:0]  save_wr,
    input  csr_pkg::csr_word_t     wmask,
    input  csr_pkg::csr_word_t     wvalue,
    output csr_pkg::csr_word_t     save_values [SAVE_COUNT]
);

    csr_pkg::csr_word_t bank [SAVE_COUNT];

    // scratch words, software owned
    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (save_wr[i]) begin
                bank[i] <= csr_pkg::masked_merge(bank[i], wmask, wvalue);
            end
        end
    end

    assign save_values = bank;

endmodule

/* verilog/csr_trap_regs.sv */
module csr_trap_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  exc_pkg::exc_event_t   exc,
    input  csr_pkg::csr_wr_t      csr_wr,
    input  csr_pkg::csr_word_t    wmask,
    input  csr_pkg::csr_word_t    wvalue,
    output csr_pkg::trap_view_t   trap_view,
    output logic                  crmd_ie,
    output csr_pkg::csr_word_t    csr_eentry
);

    logic [1:0]          crmd_plv;
    logic [1:0]          prmd_pplv;
    logic                prmd_pie;
    exc_pkg::ecode_t     estat_ecode;
    exc_pkg::esubcode_t  estat_esubcode;
    csr_pkg::csr_word_t  era;
    csr_pkg::csr_word_t  badv;
    logic [25:0]         eentry_va;
    csr_pkg::csr_word_t  crmd_word;
    csr_pkg::csr_word_t  prmd_word;
    csr_pkg::csr_word_t  crmd_next;
    csr_pkg::csr_word_t  prmd_next;
    csr_pkg::csr_word_t  eentry_next;
    logic                is_adef;
    logic                is_ale;

    // DA is fixed at one without address translation
    assign crmd_word  = {28'b0, 1'b1, crmd_ie, crmd_plv};
    assign prmd_word  = {29'b0, prmd_pie, prmd_pplv};
    assign csr_eentry = {eentry_va, 6'b0};

    assign crmd_next   = csr_pkg::masked_merge(crmd_word, wmask, wvalue);
    assign prmd_next   = csr_pkg::masked_merge(prmd_word, wmask, wvalue);
    assign eentry_next = csr_pkg::masked_merge(csr_eentry, wmask, wvalue);

    assign is_adef = (exc.ecode == exc_pkg::ECODE_ADE) && (exc.esubcode == '0);
    assign is_ale  = (exc.ecode == exc_pkg::ECODE_ALE);

    // ex beats ertn and ertn beats a software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exc.ex) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (exc.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else begin
            if (csr_wr.crmd) begin
                crmd_plv <= crmd_next[1:0];
                crmd_ie  <= crmd_next[2];
            end
            if (csr_wr.prmd) begin
                prmd_pplv <= prmd_next[1:0];
                prmd_pie  <= prmd_next[2];
            end
        end
    end

    // captured exception state
    always_ff @(posedge clk) begin
        if (exc.ex) begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
            era            <= exc.pc;
        end else if (csr_wr.era) begin
            era <= csr_pkg::masked_merge(era, wmask, wvalue);
        end
        // faulting address only for address errors
        if (exc.ex && (is_adef || is_ale)) begin
            badv <= is_adef ? exc.pc : exc.vaddr;
        end else if (csr_wr.badv) begin
            badv <= csr_pkg::masked_merge(badv, wmask, wvalue);
        end
        if (csr_wr.eentry) begin
            eentry_va <= eentry_next[31:6];
        end
    end

    assign trap_view = '{crmd: crmd_word, prmd: prmd_word, era: era, badv: badv,
                         eentry: csr_eentry, ecode: estat_ecode,
                         esubcode: estat_esubcode};

endmodule

/* verilog/csr_access.sv */
module csr_access #(
    parameter int SAVE_COUNT = 4
) (
    input  csr_pkg::csr_req_t    csr_req,
    input  csr_pkg::trap_view_t  trap_view,
    input  csr_pkg::timer_view_t timer_view,
    input  csr_pkg::intr_view_t  intr_view,
    input  csr_pkg::csr_word_t   save_values [SAVE_COUNT],
    output csr_pkg::csr_wr_t     csr_wr,
    output logic [SAVE_COUNT-1:0] save_wr,
    output csr_pkg::csr_word_t   wmask,
    output csr_pkg::csr_word_t   wvalue,
    output csr_pkg::csr_word_t   csr_rvalue
);

    csr_pkg::csr_word_t estat_word;
    csr_pkg::csr_word_t rdata;

    assign wmask  = csr_req.wmask;
    assign wvalue = csr_req.wvalue;

    // write strobes
    always_comb begin
        csr_wr.crmd   = csr_req.we && (csr_req.num == csr_pkg::CRMD);
        csr_wr.prmd   = csr_req.we && (csr_req.num == csr_pkg::PRMD);
        csr_wr.ecfg   = csr_req.we && (csr_req.num == csr_pkg::ECFG);
        csr_wr.estat  = csr_req.we && (csr_req.num == csr_pkg::ESTAT);
        csr_wr.era    = csr_req.we && (csr_req.num == csr_pkg::ERA);
        csr_wr.badv   = csr_req.we && (csr_req.num == csr_pkg::BADV);
        csr_wr.eentry = csr_req.we && (csr_req.num == csr_pkg::EENTRY);
        csr_wr.tid    = csr_req.we && (csr_req.num == csr_pkg::TID);
        csr_wr.tcfg   = csr_req.we && (csr_req.num == csr_pkg::TCFG);
        csr_wr.ticlr  = csr_req.we && (csr_req.num == csr_pkg::TICLR);
    end

    // save bank occupies consecutive numbers
    for (genvar g = 0; g < SAVE_COUNT; g++) begin : g_save_wr
        assign save_wr[g] = csr_req.we
            && (csr_req.num == csr_pkg::csr_num_t'(csr_pkg::SAVE_BASE + g));
    end

    // bit 10 is reserved
    assign estat_word = {1'b0, trap_view.esubcode, trap_view.ecode, 3'b0,
                         intr_view.is[12:11], 1'b0, intr_view.is[9:0]};

    always_comb begin
        rdata = '0;
        case (csr_req.num)
            csr_pkg::CRMD:   rdata = trap_view.crmd;
            csr_pkg::PRMD:   rdata = trap_view.prmd;
            csr_pkg::ECFG:   rdata = intr_view.ecfg;
            csr_pkg::ESTAT:  rdata = estat_word;
            csr_pkg::ERA:    rdata = trap_view.era;
            csr_pkg::BADV:   rdata = trap_view.badv;
            csr_pkg::EENTRY: rdata = trap_view.eentry;
            csr_pkg::TID:    rdata = timer_view.tid;
            csr_pkg::TCFG:   rdata = timer_view.tcfg;
            csr_pkg::TVAL:   rdata = timer_view.tval;
            default:         rdata = '0;
        endcase
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (csr_req.num == csr_pkg::csr_num_t'(csr_pkg::SAVE_BASE + i)) begin
                rdata = save_values[i];
            end
        end
    end

    assign csr_rvalue = csr_req.re ? rdata : '0;

endmodule

/* verilog/exc_pkg.sv */
package exc_pkg;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    // address error codes, ADEF is ADE with subcode zero
    localparam ecode_t ECODE_ADE = 6'h8;
    localparam ecode_t ECODE_ALE = 6'h9;

    // event of the retiring instruction
    typedef struct packed {
        logic        ex;
        logic        ertn;
        ecode_t      ecode;
        esubcode_t   esubcode;
        logic [31:0] pc;
        logic [31:0] vaddr;
    } exc_event_t;

endpackage

/* verilog/csr_pkg.sv */
package csr_pkg;

    // register numbers
    typedef logic [13:0] csr_num_t;

    localparam csr_num_t CRMD      = 14'h0;
    localparam csr_num_t PRMD      = 14'h1;
    localparam csr_num_t ECFG      = 14'h4;
    localparam csr_num_t ESTAT     = 14'h5;
    localparam csr_num_t ERA       = 14'h6;
    localparam csr_num_t BADV      = 14'h7;
    localparam csr_num_t EENTRY    = 14'hc;
    localparam csr_num_t SAVE_BASE = 14'h30;
    localparam csr_num_t TID       = 14'h40;
    localparam csr_num_t TCFG      = 14'h41;
    localparam csr_num_t TVAL      = 14'h42;
    localparam csr_num_t TICLR     = 14'h44;

    typedef logic [31:0] csr_word_t;

    // software access from the writeback stage
    typedef struct packed {
        logic      re;
        logic      we;
        csr_num_t  num;
        csr_word_t wmask;
        csr_word_t wvalue;
    } csr_req_t;

    // one strobe per register, high in the cycle it is written
    typedef struct packed {
        logic crmd;
        logic prmd;
        logic ecfg;
        logic estat;
        logic era;
        logic badv;
        logic eentry;
        logic tid;
        logic tcfg;
        logic ticlr;
    } csr_wr_t;

    typedef struct packed {
        csr_word_t   crmd;
        csr_word_t   prmd;
        csr_word_t   era;
        csr_word_t   badv;
        csr_word_t   eentry;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
    } trap_view_t;

    typedef struct packed {
        csr_word_t tid;
        csr_word_t tcfg;
        csr_word_t tval;
    } timer_view_t;

    typedef struct packed {
        csr_word_t   ecfg;
        logic [12:0] is;
    } intr_view_t;

    // bits with mask set come from wvalue, the rest keep their old value
    function automatic csr_word_t masked_merge(
        input csr_word_t old_value,
        input csr_word_t wmask,
        input csr_word_t wvalue
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage
